/* Bender.yml */
package:
  name: lsb

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsb_pkg.sv
      - hw/lsb_alloc_if.sv
      - hw/lsb_head_if.sv
      - hw/lsb_dispatch.sv
      - hw/lsb_station.sv
      - hw/lsb_issue.sv
      - hw/lsb_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_lsb.sv

/* files.f */
+incdir+hw
hw/lsb_pkg.sv
hw/lsb_alloc_if.sv
hw/lsb_head_if.sv
hw/lsb_dispatch.sv
hw/lsb_station.sv
hw/lsb_issue.sv
hw/lsb_top.sv
verif/tb_lsb.sv

/* hw/lsb_alloc_if.sv */
`timescale 1ns/1ps
`include "lsb_params.svh"

// new entry from dispatch into the station, full flag going back
interface lsb_alloc_if;
	import lsb_pkg::*;

	logic                   alloc; // one-cycle write strobe
	logic [`LSB_IDX_W-1:0]  idx;   // target slot (tail)
	logic [`LSB_ADDR_W-1:0] addr;  // effective address
	ls_op_e                 op;
	logic [`LSB_DATA_W-1:0] vi;    // store value if qi is clear
	logic [`LSB_TAG_W-1:0]  qi;    // producer tag
	logic                   full;

	modport dispatch (
		output alloc, idx, addr, op, vi, qi,
		input  full
	);

	modport station (
		input  alloc, idx, addr, op, vi, qi,
		output full
	);

endinterface

/* hw/lsb_dispatch.sv */
`timescale 1ns/1ps
`include "lsb_params.svh"

module lsb_dispatch (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  sel_i,
	input  lsb_pkg::ls_op_e       op_i,
	input  logic [`LSB_OFS_W-1:0] offset_i,
	input  lsb_pkg::data_t        rs_i,
	input  lsb_pkg::data_t        vi_i,
	input  lsb_pkg::tag_t         qi_i,
	lsb_alloc_if.dispatch         alloc,
	output lsb_pkg::idx_t         ls_entry_o
);
	import lsb_pkg::*;

	idx_t  tail;
	idx_t  tail_nxt;
	data_t ea_sum;

	// base plus zero-extended offset
	assign ea_sum = rs_i + data_t'(offset_i);

	// a full buffer drops the instruction and the sender watches ls_full_o
	assign alloc.alloc = sel_i & ~alloc.full;
	assign alloc.idx   = tail;
	assign alloc.addr  = ea_sum[`LSB_ADDR_W-1:0]; // upper bits dropped
	assign alloc.op    = op_i;
	assign alloc.vi    = vi_i;
	assign alloc.qi    = qi_i;

	assign tail_nxt = (tail == idx_t'(`LSB_ENTRIES - 1)) ? '0 : tail + idx_t'(1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tail <= '0;
		end else if (alloc.alloc) begin
			tail <= tail_nxt; // wraps 5 -> 0
		end
	end

	assign ls_entry_o = tail;

	// whatever the station accepts must be a memory op
	a_op_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		alloc.alloc |-> (op_i inside {OP_LOAD, OP_STORE})
	) else $error("dispatch accepted op %0h", op_i);

endmodule

/* hw/lsb_head_if.sv */
`timescale 1ns/1ps
`include "lsb_params.svh"

// head slot view for the issue stage
interface lsb_head_if;
	import lsb_pkg::*;

	logic [`LSB_IDX_W-1:0]  head;   // slot being looked at
	logic                   retire; // frees head at the edge
	logic                   busy;
	logic                   ready;  // load, or store with data in hand
	ls_op_e                 op;
	logic [`LSB_ADDR_W-1:0] addr;
	logic [`LSB_DATA_W-1:0] vi;

	modport issue (
		output head, retire,
		input  busy, ready, op, addr, vi
	);

	modport station (
		input  head, retire,
		output busy, ready, op, addr, vi
	);

endinterface

/* hw/lsb_issue.sv */
`timescale 1ns/1ps
`include "lsb_params.svh"

module lsb_issue (
	input  logic                    clk,
	input  logic                    rst_n,
	lsb_head_if.issue               head,
	output lsb_pkg::addr_t          mem_addr_o,
	output lsb_pkg::data_t          data_o,
	output logic                    wen_o,
	output logic [`LSB_ENTRIES-1:0] valid_o
);
	import lsb_pkg::*;

	idx_t head_q;
	idx_t head_nxt;
	logic is_store;

	assign head.head = head_q;

	// head goes out as soon as it is occupied and has what it needs
	assign head.retire = head.busy & head.ready;

	assign head_nxt = (head_q == idx_t'(`LSB_ENTRIES - 1)) ? '0 : head_q + idx_t'(1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head_q <= '0;
		end else if (head.retire) begin
			head_q <= head_nxt;
		end
	end

	assign is_store = (head.op == OP_STORE);

	// memory side stays quiet unless something issues this cycle
	assign valid_o    = head.retire ? (`LSB_ENTRIES'(1) << head_q) : '0;
	assign mem_addr_o = head.retire ? head.addr : '0;
	assign wen_o      = head.retire & is_store;
	assign data_o     = wen_o ? head.vi : '0; // loads carry no data

	a_valid_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(valid_o)
	) else $error("valid_o not one-hot: %b", valid_o);

endmodule

/* hw/lsb_params.svh */
`ifndef LSB_PARAMS_SVH
`define LSB_PARAMS_SVH

// buffer geometry, six slots fit the load tag range 1..6
`define LSB_ENTRIES 6
`define LSB_IDX_W   3

// memory side
`define LSB_ADDR_W  19
`define LSB_DATA_W  32

// instruction fields
`define LSB_OFS_W   12 // unsigned immediate
`define LSB_OP_W    3

// common data bus
`define LSB_TAG_W   4

`endif

/* hw/lsb_pkg.sv */
`include "lsb_params.svh"

package lsb_pkg;

	// only loads and stores reach this buffer
	typedef enum logic [`LSB_OP_W-1:0] {
		OP_LOAD  = `LSB_OP_W'(4),
		OP_STORE = `LSB_OP_W'(5)
	} ls_op_e;

	typedef logic [`LSB_TAG_W-1:0]  tag_t;
	typedef logic [`LSB_DATA_W-1:0] data_t;
	typedef logic [`LSB_ADDR_W-1:0] addr_t;
	typedef logic [`LSB_IDX_W-1:0]  idx_t;

	// cdb source tags
	localparam tag_t TAG_NONE    = tag_t'(0); // value already present
	localparam tag_t TAG_LS_BASE = tag_t'(1); // load slot n broadcasts n+1
	localparam tag_t TAG_ADD1    = tag_t'(7);
	localparam tag_t TAG_ADD2    = tag_t'(8);
	localparam tag_t TAG_ADD3    = tag_t'(9);
	localparam tag_t TAG_MUL1    = tag_t'(10);
	localparam tag_t TAG_MUL2    = tag_t'(11);

endpackage

/* hw/lsb_station.sv */
`timescale 1ns/1ps
`include "lsb_params.svh"

module lsb_station (
	input  logic           clk,
	input  logic           rst_n,
	lsb_alloc_if.station   alloc,
	lsb_head_if.station    head,
	input  logic           add1_valid_i,
	input  logic           add2_valid_i,
	input  logic           add3_valid_i,
	input  logic           mul1_valid_i,
	input  logic           mul2_valid_i,
	input  logic           ls_valid_i,
	input  lsb_pkg::data_t add1_result_i,
	input  lsb_pkg::data_t add2_result_i,
	input  lsb_pkg::data_t add3_result_i,
	input  lsb_pkg::data_t mul1_result_i,
	input  lsb_pkg::data_t mul2_result_i,
	input  lsb_pkg::data_t ls_value_i,
	input  lsb_pkg::idx_t  ls_idx_i
);
	import lsb_pkg::*;

	logic [`LSB_ENTRIES-1:0] busy;
	ls_op_e                  op_q [`LSB_ENTRIES];
	addr_t                   addr_q [`LSB_ENTRIES];
	data_t                   vi_q [`LSB_ENTRIES];
	tag_t                    qi_q [`LSB_ENTRIES];

	logic [`LSB_ENTRIES-1:0] hit;
	data_t                   wake_val [`LSB_ENTRIES];
	tag_t                    ls_tag;

	assign ls_tag = TAG_LS_BASE + tag_t'(ls_idx_i); // load slot n -> tag n+1

	// cdb snoop, each slot compares its own tag
	always_comb begin
		for (int i = 0; i < `LSB_ENTRIES; i++) begin
			hit[i] = 1'b1;
			if (ls_valid_i && qi_q[i] == ls_tag) begin
				wake_val[i] = ls_value_i; // load results win
			end else if (add1_valid_i && qi_q[i] == TAG_ADD1) begin
				wake_val[i] = add1_result_i;
			end else if (add2_valid_i && qi_q[i] == TAG_ADD2) begin
				wake_val[i] = add2_result_i;
			end else if (add3_valid_i && qi_q[i] == TAG_ADD3) begin
				wake_val[i] = add3_result_i;
			end else if (mul1_valid_i && qi_q[i] == TAG_MUL1) begin
				wake_val[i] = mul1_result_i;
			end else if (mul2_valid_i && qi_q[i] == TAG_MUL2) begin
				wake_val[i] = mul2_result_i;
			end else begin
				hit[i]      = 1'b0;
				wake_val[i] = vi_q[i];
			end
			// a free slot or one already holding its value never wakes
			hit[i] = hit[i] && busy[i] && (qi_q[i] != TAG_NONE);
		end
	end

	// slot occupancy
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= '0;
		end else begin
			for (int i = 0; i < `LSB_ENTRIES; i++) begin
				if (alloc.alloc && alloc.idx == idx_t'(i)) begin
					busy[i] <= 1'b1;
				end else if (head.retire && head.head == idx_t'(i)) begin
					busy[i] <= 1'b0; // issued, slot is free again
				end
			end
		end
	end

	// entry payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < `LSB_ENTRIES; i++) begin
			if (alloc.alloc && alloc.idx == idx_t'(i)) begin
				op_q[i]   <= alloc.op;
				addr_q[i] <= alloc.addr;
				vi_q[i]   <= alloc.vi;
				qi_q[i]   <= alloc.qi;
			end else if (hit[i]) begin
				vi_q[i] <= wake_val[i];
				qi_q[i] <= TAG_NONE;
			end
		end
	end

	assign alloc.full = &busy;

	// head slot view
	assign head.busy  = busy[head.head];
	assign head.op    = op_q[head.head];
	assign head.addr  = addr_q[head.head];
	assign head.vi    = vi_q[head.head];
	assign head.ready = busy[head.head] &&
		(op_q[head.head] == OP_LOAD || qi_q[head.head] == TAG_NONE);

	// dispatch's tail must never run over a live entry
	a_alloc_free: assert property (
		@(posedge clk) disable iff (!rst_n)
		alloc.alloc |-> !busy[alloc.idx]
	) else $error("allocation into busy slot %0d", alloc.idx);

	a_retire_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		head.retire |-> busy[head.head]
	) else $error("retire of free slot %0d", head.head);

endmodule

/* hw/lsb_top.sv */
`timescale 1ns/1ps
`include "lsb_params.svh"

module lsb_top (
	input  logic                    clk,
	input  logic                    rst_n,
	// instruction side
	input  logic                    sel_i,
	input  lsb_pkg::ls_op_e         op_i,
	input  logic [`LSB_OFS_W-1:0]   offset_i,
	input  lsb_pkg::data_t          rs_i,  // base register
	input  lsb_pkg::data_t          vi_i,  // store value
	input  lsb_pkg::tag_t           qi_i,  // store value producer
	// common data bus
	input  logic                    add1_valid_i,
	input  logic                    add2_valid_i,
	input  logic                    add3_valid_i,
	input  logic                    mul1_valid_i,
	input  logic                    mul2_valid_i,
	input  logic                    ls_valid_i,
	input  lsb_pkg::data_t          add1_result_i,
	input  lsb_pkg::data_t          add2_result_i,
	input  lsb_pkg::data_t          add3_result_i,
	input  lsb_pkg::data_t          mul1_result_i,
	input  lsb_pkg::data_t          mul2_result_i,
	input  lsb_pkg::data_t          ls_value_i,
	input  lsb_pkg::idx_t           ls_idx_i,
	// memory side
	output lsb_pkg::addr_t          mem_addr_o,
	output lsb_pkg::data_t          data_o,
	output logic                    wen_o,
	output logic [`LSB_ENTRIES-1:0] valid_o,
	// to instruction manager
	output logic                    ls_full_o,
	output lsb_pkg::idx_t           ls_entry_o
);

	lsb_alloc_if u_alloc_if ();
	lsb_head_if  u_head_if ();

	lsb_dispatch u_dispatch (
		.clk        (clk),
		.rst_n      (rst_n),
		.sel_i      (sel_i),
		.op_i       (op_i),
		.offset_i   (offset_i),
		.rs_i       (rs_i),
		.vi_i       (vi_i),
		.qi_i       (qi_i),
		.alloc      (u_alloc_if.dispatch),
		.ls_entry_o (ls_entry_o)
	);

	lsb_station u_station (
		.clk           (clk),
		.rst_n         (rst_n),
		.alloc         (u_alloc_if.station),
		.head          (u_head_if.station),
		.add1_valid_i  (add1_valid_i),
		.add2_valid_i  (add2_valid_i),
		.add3_valid_i  (add3_valid_i),
		.mul1_valid_i  (mul1_valid_i),
		.mul2_valid_i  (mul2_valid_i),
		.ls_valid_i    (ls_valid_i),
		.add1_result_i (add1_result_i),
		.add2_result_i (add2_result_i),
		.add3_result_i (add3_result_i),
		.mul1_result_i (mul1_result_i),
		.mul2_result_i (mul2_result_i),
		.ls_value_i    (ls_value_i),
		.ls_idx_i      (ls_idx_i)
	);

	lsb_issue u_issue (
		.clk        (clk),
		.rst_n      (rst_n),
		.head       (u_head_if.issue),
		.mem_addr_o (mem_addr_o),
		.data_o     (data_o),
		.wen_o      (wen_o),
		.valid_o    (valid_o)
	);

	assign ls_full_o = u_alloc_if.full;

endmodule

/* verif/tb_lsb.sv */
`timescale 1ns/1ps
`include "lsb_params.svh"

module tb_lsb;
	import lsb_pkg::*;

	localparam int CLK_PERIOD = 100;

	typedef struct {
		logic       sel;
		ls_op_e     op;
		data_t      rs;
		logic [11:0] ofs;
		data_t      vi;
		tag_t       qi;
		logic [5:0] cdb_src; // bit 0 load, then add1..add3, mul1, mul2
		idx_t       ls_idx;
		data_t      cdb_val;
		logic [`LSB_ENTRIES-1:0] exp_valid;
		addr_t      exp_addr;
		data_t      exp_data;
		logic       exp_wen;
		logic       exp_full;
		idx_t       exp_tail;
	} row_t;

	// one accepted instruction as the reference queue sees it
	typedef struct packed {
		idx_t  slot;
		logic  store;
		addr_t addr;
		data_t val;
		tag_t  tag;
	} ref_entry_t;

	logic clk;
	logic rst_n;
	logic sel_i;
	ls_op_e op_i;
	logic [`LSB_OFS_W-1:0] offset_i;
	data_t rs_i;
	data_t vi_i;
	tag_t qi_i;
	logic add1_valid_i;
	logic add2_valid_i;
	logic add3_valid_i;
	logic mul1_valid_i;
	logic mul2_valid_i;
	logic ls_valid_i;
	data_t add1_result_i;
	data_t add2_result_i;
	data_t add3_result_i;
	data_t mul1_result_i;
	data_t mul2_result_i;
	data_t ls_value_i;
	idx_t ls_idx_i;
	addr_t mem_addr_o;
	data_t data_o;
	logic wen_o;
	logic [`LSB_ENTRIES-1:0] valid_o;
	logic ls_full_o;
	idx_t ls_entry_o;

	row_t rows[$];
	logic [31:0] rng_state = 32'heb33;
	logic table_done = 1'b0;
	int errors = 0;
	int checks = 0;

	lsb_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// tag that CDB source k broadcasts
	function automatic tag_t src_tag(input int k, input idx_t ls_idx);
		case (k)
			0: return TAG_LS_BASE + tag_t'(ls_idx);
			1: return TAG_ADD1;
			2: return TAG_ADD2;
			3: return TAG_ADD3;
			4: return TAG_MUL1;
			5: return TAG_MUL2;
			default: return TAG_NONE;
		endcase
	endfunction

	function automatic data_t src_val(input int k, input data_t base);
		return base + data_t'(k) * 32'h0101_0101; // distinct per source
	endfunction

	task automatic add_row(input logic sel, input ls_op_e op, input tag_t qi,
			input logic [5:0] src, input idx_t ls_idx);
		row_t  row;
		data_t ofs_rand;
		row.sel     = sel;
		row.op      = op;
		row.rs      = next_rand();
		ofs_rand    = next_rand();
		row.ofs     = ofs_rand[11:0];
		row.vi      = next_rand();
		row.qi      = qi;
		row.cdb_src = src;
		row.ls_idx  = ls_idx;
		row.cdb_val = next_rand();
		rows.push_back(row);
	endtask

	task automatic add_idle(input int n);
		repeat (n) add_row(1'b0, OP_LOAD, TAG_NONE, 6'b0, '0);
	endtask

	// walks the table with a queue of accepted entries held oldest first
	task automatic fill_expected();
		ref_entry_t q[$];
		ref_entry_t e;
		idx_t       tail;
		logic       full;
		logic       issue;
		tail = '0;
		foreach (rows[r]) begin
			full  = (q.size() == `LSB_ENTRIES);
			issue = (q.size() > 0) && (!q[0].store || q[0].tag == TAG_NONE);
			rows[r].exp_full  = full;
			rows[r].exp_tail  = tail;
			rows[r].exp_valid = '0;
			rows[r].exp_addr  = '0;
			rows[r].exp_data  = '0;
			rows[r].exp_wen   = 1'b0;
			if (issue) begin
				rows[r].exp_valid = `LSB_ENTRIES'(1) << q[0].slot;
				rows[r].exp_addr  = q[0].addr;
				rows[r].exp_wen   = q[0].store;
				rows[r].exp_data  = q[0].store ? q[0].val : '0;
			end
			// what happens at the edge closing this row
			for (int i = 0; i < q.size(); i++) begin
				for (int k = 0; k < 6; k++) begin // priority order
					if (q[i].store && q[i].tag != TAG_NONE && rows[r].cdb_src[k] &&
							src_tag(k, rows[r].ls_idx) == q[i].tag) begin
						q[i].val = src_val(k, rows[r].cdb_val);
						q[i].tag = TAG_NONE;
					end
				end
			end
			if (issue)
				void'(q.pop_front());
			if (rows[r].sel && !full) begin
				e.slot  = tail;
				e.store = (rows[r].op == OP_STORE);
				// only the low address bits take part, the carry out is lost
				e.addr  = rows[r].rs[`LSB_ADDR_W-1:0] + addr_t'(rows[r].ofs);
				e.val   = rows[r].vi;
				e.tag   = e.store ? rows[r].qi : TAG_NONE;
				q.push_back(e);
				tail = (tail == idx_t'(`LSB_ENTRIES - 1)) ? '0 : tail + idx_t'(1);
			end
		end
	endtask

	task automatic drive_row(input row_t row);
		sel_i         = row.sel;
		op_i          = row.op;
		rs_i          = row.rs;
		offset_i      = row.ofs;
		vi_i          = row.vi;
		qi_i          = row.qi;
		ls_valid_i    = row.cdb_src[0];
		add1_valid_i  = row.cdb_src[1];
		add2_valid_i  = row.cdb_src[2];
		add3_valid_i  = row.cdb_src[3];
		mul1_valid_i  = row.cdb_src[4];
		mul2_valid_i  = row.cdb_src[5];
		ls_value_i    = src_val(0, row.cdb_val);
		add1_result_i = src_val(1, row.cdb_val);
		add2_result_i = src_val(2, row.cdb_val);
		add3_result_i = src_val(3, row.cdb_val);
		mul1_result_i = src_val(4, row.cdb_val);
		mul2_result_i = src_val(5, row.cdb_val);
		ls_idx_i      = row.ls_idx;
	endtask

	task automatic check_row(input int r);
		checks++;
		if (valid_o !== rows[r].exp_valid) begin
			$display("ERROR: valid_o expected %0h got %0h, row %0d", rows[r].exp_valid, valid_o, r);
			errors++;
		end
		if (rows[r].exp_valid != 0 && mem_addr_o !== rows[r].exp_addr) begin
			$display("ERROR: mem_addr_o expected %0h got %0h, row %0d", rows[r].exp_addr,
				mem_addr_o, r);
			errors++;
		end
		if (wen_o !== rows[r].exp_wen) begin
			$display("ERROR: wen_o expected %0h got %0h, row %0d", rows[r].exp_wen, wen_o, r);
			errors++;
		end
		if (rows[r].exp_wen && data_o !== rows[r].exp_data) begin
			$display("ERROR: data_o expected %0h got %0h, row %0d", rows[r].exp_data, data_o, r);
			errors++;
		end
		if (ls_full_o !== rows[r].exp_full) begin
			$display("ERROR: ls_full_o expected %0h got %0h, row %0d", rows[r].exp_full,
				ls_full_o, r);
			errors++;
		end
		if (ls_entry_o !== rows[r].exp_tail) begin
			$display("ERROR: ls_entry_o expected %0h got %0h, row %0d", rows[r].exp_tail,
				ls_entry_o, r);
			errors++;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		drive_row('{op: OP_LOAD, default: '0});

		repeat (8) add_row(1'b1, OP_LOAD, TAG_NONE, 6'b0, '0); // tail wraps past 5
		add_idle(2);
		add_row(1'b1, OP_STORE, TAG_NONE, 6'b0, '0);
		add_idle(2);
		// store waiting on mul1 holds back two loads
		add_row(1'b1, OP_STORE, TAG_MUL1, 6'b0, '0);
		repeat (2) add_row(1'b1, OP_LOAD, TAG_NONE, 6'b0, '0);
		add_row(1'b0, OP_LOAD, TAG_NONE, 6'b000100, '0); // add2 alone does not match
		add_idle(1);
		add_row(1'b0, OP_LOAD, TAG_NONE, 6'b010000, '0);
		add_idle(4);
		add_row(1'b1, OP_STORE, 4'd3, 6'b0, '0); // waits on load slot 2
		add_idle(1);
		add_row(1'b0, OP_LOAD, TAG_NONE, 6'b000001, idx_t'(2));
		add_idle(2);
		// load index 6 maps onto the add1 tag and the load result must win
		add_row(1'b1, OP_STORE, TAG_ADD1, 6'b0, '0);
		add_idle(1);
		add_row(1'b0, OP_LOAD, TAG_NONE, 6'b000011, idx_t'(6));
		add_idle(2);
		repeat (6) add_row(1'b1, OP_STORE, TAG_MUL2, 6'b0, '0);
		add_row(1'b1, OP_LOAD, TAG_NONE, 6'b0, '0); // dropped because the buffer is full
		add_idle(1);
		add_row(1'b1, OP_LOAD, TAG_NONE, 6'b100000, '0);
		repeat (3) add_row(1'b1, OP_LOAD, TAG_NONE, 6'b0, '0);
		add_idle(8);

		fill_expected();
		table_done = 1'b1;

		repeat (4) @(posedge clk);
		#10;
		rst_n = 1'b1;
		foreach (rows[r]) begin
			drive_row(rows[r]);
			#(CLK_PERIOD - 20);
			check_row(r);
			@(posedge clk);
			#10;
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (table_done);
		#((rows.size() * 4 + 20) * CLK_PERIOD);
		$display("timeout: the stimulus table did not complete in time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
